//--- Makefile
VERILATOR  ?= verilator
TOP        := decode_front_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
common/core_pkg.sv
common/isa_pkg.sv
common/front_if.sv
logic/fetch_stage.sv
logic/inst_decoder.sv
logic/ds_queue.sv
logic/decode_front.sv
bench/decode_front_assert.sv
bench/decode_front_tb.sv

//--- bench/decode_front_assert.sv
`timescale 1ns/1ps

module decode_front_assert (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 flush_i,
    input  logic                 full,
    input  logic                 push,
    input  logic                 pop,
    input  logic                 out_valid_o,
    input  logic                 out_ready_i,
    input  core_pkg::pc_t        out_pc_o,
    input  core_pkg::inst_id_t   out_inst_id_o,
    input  core_pkg::xlen_t      out_imm_o
);

    // full queue takes a packet only when the head leaves on that edge
    a_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
        (push && full) |-> pop)
        else $error("push into a full queue without a pop");

    // flush empties the queue at once
    a_empty_after_flush: assert property (@(posedge clk) disable iff (rst_i)
        flush_i |=> !out_valid_o)
        else $error("queue still valid in the cycle after a flush");

    // waiting head holds still until it is taken
    a_head_stable: assert property (@(posedge clk) disable iff (rst_i)
        (out_valid_o && !out_ready_i && !flush_i) |=>
        (out_valid_o && $stable(out_pc_o) && $stable(out_inst_id_o) && $stable(out_imm_o)))
        else $error("head packet changed while waiting");

endmodule

bind ds_queue decode_front_assert u_queue_assert (
    .clk           (clk),
    .rst_i         (rst_i),
    .flush_i       (flush_i),
    .full          (full),
    .push          (push),
    .pop           (pop),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .out_pc_o      (out_pc_o),
    .out_inst_id_o (out_inst_id_o),
    .out_imm_o     (out_imm_o)
);

//--- bench/decode_front_tb.sv
`timescale 1ns/1ps

module decode_front_tb;

    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST;

    logic                   clk = 1'b0;
    logic                   rst_i;
    logic                   iresp_valid_i;
    logic                   iresp_ready_o;
    core_pkg::pc_t          iresp_addr_i;
    core_pkg::inst_t        iresp_inst_i;
    core_pkg::inst_id_t     iresp_id_i;
    logic                   ireq_valid_o;
    core_pkg::pc_t          ireq_addr_o;
    logic                   redirect_i;
    core_pkg::pc_t          redirect_addr_i;
    logic                   out_valid_o;
    logic                   out_ready_i;
    core_pkg::pc_t          out_pc_o;
    core_pkg::inst_id_t     out_inst_id_o;
    isa_pkg::inst_class_e   out_class_o;
    core_pkg::reg_addr_t    out_rd_o;
    core_pkg::reg_addr_t    out_rs1_o;
    core_pkg::reg_addr_t    out_rs2_o;
    isa_pkg::funct3_t       out_funct3_o;
    core_pkg::xlen_t        out_imm_o;
    logic                   out_rf_wen_o;

    // accepted responses still on their way to the output
    core_pkg::inst_t        exp_inst [$];
    core_pkg::pc_t          exp_pc [$];
    core_pkg::inst_id_t     exp_id [$];
    int                     exp_step [$];

    integer                 seed;
    string                  cur_test;
    int                     step_no;
    int                     err_count;
    int                     err_at_start;
    int                     test_count;
    int                     fail_count;
    logic                   accepted;
    logic                   latency_check;
    logic                   ireq_expect;
    logic                   drop_expect;
    core_pkg::pc_t          ireq_addr_exp;
    core_pkg::pc_t          next_pc;
    core_pkg::inst_id_t     next_id;
    isa_pkg::inst_class_e   last_class;
    logic                   last_wen;

    decode_front dut0 (.*);

    always #10 clk = ~clk;

    task automatic report_value(input string what, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        err_count++;
        $display("Error %s: %s expected %h actual %h", cur_test, what, exp_v, act_v);
    endtask

    task automatic report_fault(input string msg);
        err_count++;
        $display("%s: %s", cur_test, msg);
    endtask

    // class, immediate and write flag straight from the rv32i encoding
    task automatic predict_packet(input core_pkg::inst_t inst,
                                  output isa_pkg::inst_class_e cls,
                                  output core_pkg::xlen_t imm, output logic wen);
        core_pkg::xlen_t sext;
        sext = inst[31] ? 32'hffff_ffff : 32'h0;
        case (inst[6:0])
            7'h33:   cls = isa_pkg::CLASS_OP;
            7'h13:   cls = isa_pkg::CLASS_OP_IMM;
            7'h03:   cls = isa_pkg::CLASS_LOAD;
            7'h23:   cls = isa_pkg::CLASS_STORE;
            7'h63:   cls = isa_pkg::CLASS_BRANCH;
            7'h6f:   cls = isa_pkg::CLASS_JAL;
            7'h67:   cls = isa_pkg::CLASS_JALR;
            7'h37:   cls = isa_pkg::CLASS_LUI;
            7'h17:   cls = isa_pkg::CLASS_AUIPC;
            7'h73:   cls = isa_pkg::CLASS_SYSTEM;
            default: cls = isa_pkg::CLASS_ILLEGAL;
        endcase
        // sign fill shifted above the field bits
        case (cls)
            isa_pkg::CLASS_OP_IMM, isa_pkg::CLASS_LOAD, isa_pkg::CLASS_JALR:
                imm = (sext << 12) | 32'(inst[31:20]);
            isa_pkg::CLASS_STORE:
                imm = (sext << 12) | (32'(inst[31:25]) << 5) | 32'(inst[11:7]);
            isa_pkg::CLASS_BRANCH:
                imm = (sext << 12) | (32'(inst[7]) << 11) | (32'(inst[30:25]) << 5)
                      | (32'(inst[11:8]) << 1);
            isa_pkg::CLASS_JAL:
                imm = (sext << 20) | (32'(inst[19:12]) << 12) | (32'(inst[20]) << 11)
                      | (32'(inst[30:21]) << 1);
            isa_pkg::CLASS_LUI, isa_pkg::CLASS_AUIPC:
                imm = inst & 32'hffff_f000;
            // csr immediate forms carry uimm in the rs1 field
            isa_pkg::CLASS_SYSTEM:
                imm = inst[14] ? 32'(inst[19:15]) : ((sext << 12) | 32'(inst[31:20]));
            default:
                imm = '0;
        endcase
        // result-producing classes write unless rd is x0
        wen = (cls inside {isa_pkg::CLASS_OP, isa_pkg::CLASS_OP_IMM, isa_pkg::CLASS_LOAD,
                           isa_pkg::CLASS_JAL, isa_pkg::CLASS_JALR, isa_pkg::CLASS_LUI,
                           isa_pkg::CLASS_AUIPC, isa_pkg::CLASS_SYSTEM})
              && (inst[11:7] != 5'd0);
    endtask

    // head packet against the oldest accepted response
    task automatic compare_head();
        core_pkg::inst_t        inst;
        core_pkg::pc_t          pc;
        core_pkg::inst_id_t     id;
        int                     acc_step;
        isa_pkg::inst_class_e   cls;
        core_pkg::xlen_t        imm;
        logic                   wen;
        inst     = exp_inst.pop_front();
        pc       = exp_pc.pop_front();
        id       = exp_id.pop_front();
        acc_step = exp_step.pop_front();
        predict_packet(inst, cls, imm, wen);
        if (out_pc_o !== pc) report_value("pc", pc, out_pc_o);
        if (out_inst_id_o !== id) report_value("inst_id", 32'(id), 32'(out_inst_id_o));
        if (out_class_o !== cls) report_value("class", 32'(cls), 32'(out_class_o));
        if (out_rd_o !== inst[11:7]) report_value("rd", 32'(inst[11:7]), 32'(out_rd_o));
        if (out_rs1_o !== inst[19:15]) report_value("rs1", 32'(inst[19:15]), 32'(out_rs1_o));
        if (out_rs2_o !== inst[24:20]) report_value("rs2", 32'(inst[24:20]), 32'(out_rs2_o));
        if (out_funct3_o !== inst[14:12]) begin
            report_value("funct3", 32'(inst[14:12]), 32'(out_funct3_o));
        end
        if (out_imm_o !== imm) report_value("imm", imm, out_imm_o);
        if (out_rf_wen_o !== wen) report_value("rf_wen", 32'(wen), 32'(out_rf_wen_o));
        // accepted on one edge and visible after the next
        if (latency_check && (step_no - acc_step != 2)) begin
            report_value("latency", 32'd2, 32'(step_no - acc_step));
        end
        last_class = out_class_o;
        last_wen   = out_rf_wen_o;
    endtask

    // sample mid-cycle and book the handshakes of the coming edge
    task automatic clock_step();
        logic exp_ready;
        @(negedge clk);
        step_no++;
        exp_ready = !(redirect_i || drop_expect) && !(exp_inst.size() == 3 && !out_ready_i);
        if (iresp_ready_o !== exp_ready) begin
            report_value("iresp_ready_o", 32'(exp_ready), 32'(iresp_ready_o));
        end
        if (ireq_valid_o !== ireq_expect) begin
            report_value("ireq_valid_o", 32'(ireq_expect), 32'(ireq_valid_o));
        end else if (ireq_expect && ireq_addr_o !== ireq_addr_exp) begin
            report_value("ireq_addr_o", ireq_addr_exp, ireq_addr_o);
        end
        if (out_valid_o && exp_inst.size() == 0) begin
            report_fault("output valid with no accepted response behind it");
        end else if (!redirect_i && out_valid_o && out_ready_i) begin
            compare_head();
        end
        // redirect drops everything in flight
        if (redirect_i) begin
            exp_inst.delete();
            exp_pc.delete();
            exp_id.delete();
            exp_step.delete();
        end
        accepted = iresp_valid_i && iresp_ready_o;
        if (accepted) begin
            exp_inst.push_back(iresp_inst_i);
            exp_pc.push_back(iresp_addr_i);
            exp_id.push_back(iresp_id_i);
            exp_step.push_back(step_no);
            next_pc += 4;
            next_id++;
        end
        ireq_expect   = redirect_i;
        ireq_addr_exp = redirect_addr_i;
        drop_expect   = redirect_i;
        @(posedge clk);
        #2;
    endtask

    task automatic send_inst(input core_pkg::inst_t inst);
        int n;
        iresp_valid_i = 1'b1;
        iresp_addr_i  = next_pc;
        iresp_inst_i  = inst;
        iresp_id_i    = next_id;
        n = 0;
        accepted = 1'b0;
        while (!accepted && n < 50) begin
            clock_step();
            n++;
        end
        if (!accepted) report_fault("response never accepted");
        iresp_valid_i = 1'b0;
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        while (exp_inst.size() != 0 && n < limit) begin
            clock_step();
            n++;
        end
        if (exp_inst.size() != 0) begin
            report_fault($sformatf("%0d packets never came out", exp_inst.size()));
        end
    endtask

    // one encoding per class with csrrw at 9 and csrrwi at 10
    function automatic core_pkg::inst_t class_word(input int idx);
        case (idx)
            0:       return 32'h002081b3;
            1:       return 32'hfff30293;
            2:       return 32'h00812383;
            3:       return 32'hfe512e23;
            4:       return 32'hfe208ee3;
            5:       return 32'h800000ef;
            6:       return 32'h000080e7;
            7:       return 32'h123452b7;
            8:       return 32'hfffff317;
            9:       return 32'h300290f3;
            default: return 32'h3002d0f3;
        endcase
    endfunction

    task automatic start_test(input string name);
        cur_test     = name;
        err_at_start = err_count;
        test_count++;
    endtask

    task automatic close_test();
        if (err_count == err_at_start) begin
            $display("%s: ok", cur_test);
        end else begin
            fail_count++;
            $display("%s: %0d errors", cur_test, err_count - err_at_start);
        end
    endtask

    task automatic check_reset_state();
        start_test("reset_state");
        @(negedge clk);
        if (out_valid_o !== 1'b0) report_value("out_valid_o", 32'd0, 32'(out_valid_o));
        if (ireq_valid_o !== 1'b0) report_value("ireq_valid_o", 32'd0, 32'(ireq_valid_o));
        if (iresp_ready_o !== 1'b1) report_value("iresp_ready_o", 32'd1, 32'(iresp_ready_o));
        @(posedge clk);
        #2;
        repeat (2) clock_step();
        close_test();
    endtask

    task automatic check_each_class();
        start_test("each_class");
        out_ready_i   = 1'b1;
        latency_check = 1'b1;
        for (int i = 0; i < 11; i++) begin
            send_inst(class_word(i));
        end
        drain(20);
        latency_check = 1'b0;
        close_test();
    endtask

    // random words and random pace on both channels
    task automatic check_random_stream();
        int               sent;
        int               n;
        int               idx;
        logic             offering;
        logic [31:0]      r;
        core_pkg::inst_t  w;
        start_test("random_stream");
        sent = 0;
        n = 0;
        offering = 1'b0;
        while (sent < 60 && n < 400) begin
            r = $random(seed);
            if (!offering && r[1:0] != 2'b00) begin
                idx = int'(r[15:8]) % 12;
                w = class_word(idx);
                r = $random(seed);
                iresp_valid_i = 1'b1;
                iresp_addr_i  = next_pc;
                iresp_id_i    = next_id;
                // 11 stands for an unknown opcode
                iresp_inst_i  = {r[31:7], (idx == 11) ? 7'h7f : w[6:0]};
                offering = 1'b1;
            end
            r = $random(seed);
            out_ready_i = r[0];
            clock_step();
            n++;
            if (accepted) begin
                sent++;
                offering = 1'b0;
                iresp_valid_i = 1'b0;
            end
        end
        if (sent < 60) report_fault("stream stalled before all responses went in");
        iresp_valid_i = 1'b0;
        out_ready_i = 1'b1;
        drain(20);
        close_test();
    endtask

    task automatic check_redirect_full();
        start_test("redirect_full");
        out_ready_i = 1'b0;
        send_inst(32'h00a00093);
        send_inst(32'h00b00113);
        send_inst(32'h00c00193);
        // fourth response meets the redirect
        iresp_valid_i   = 1'b1;
        iresp_addr_i    = next_pc;
        iresp_inst_i    = 32'h00d00213;
        iresp_id_i      = next_id;
        redirect_i      = 1'b1;
        redirect_addr_i = 32'h0000_4000;
        clock_step();
        if (accepted) report_fault("response accepted on the redirect edge");
        redirect_i = 1'b0;
        // the request must carry the address sampled on the redirect edge
        redirect_addr_i = 32'h0000_8000;
        clock_step();
        if (accepted) report_fault("response accepted in the cycle after the redirect");
        iresp_valid_i = 1'b0;
        out_ready_i = 1'b1;
        // stale packets would show up here
        repeat (6) clock_step();
        next_pc = 32'h0000_4000;
        send_inst(32'h00100113);
        drain(20);
        close_test();
    endtask

    task automatic check_illegal_and_x0();
        start_test("illegal_and_x0");
        out_ready_i = 1'b1;
        send_inst(32'h00a105fb);
        drain(20);
        if (last_class !== isa_pkg::CLASS_ILLEGAL) begin
            report_value("class", 32'(isa_pkg::CLASS_ILLEGAL), 32'(last_class));
        end
        if (last_wen !== 1'b0) report_value("rf_wen", 32'd0, 32'(last_wen));
        // addi x0, x1, 5
        send_inst(32'h00508013);
        drain(20);
        if (last_wen !== 1'b0) report_value("rf_wen", 32'd0, 32'(last_wen));
        close_test();
    endtask

    initial begin
        rst_i           = 1'b1;
        iresp_valid_i   = 1'b0;
        iresp_addr_i    = '0;
        iresp_inst_i    = '0;
        iresp_id_i      = '0;
        redirect_i      = 1'b0;
        redirect_addr_i = '0;
        out_ready_i     = 1'b0;
        seed            = 32'h9ddaa313;
        step_no         = 0;
        err_count       = 0;
        test_count      = 0;
        fail_count      = 0;
        latency_check   = 1'b0;
        ireq_expect     = 1'b0;
        drop_expect     = 1'b0;
        ireq_addr_exp   = '0;
        next_pc         = 32'h0000_1000;
        next_id         = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_i = 1'b0;
        check_reset_state();
        check_each_class();
        check_random_stream();
        check_redirect_full();
        check_illegal_and_x0();
        $display("%0d tests run, %0d with errors, %0d errors total",
                 test_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // bound to the test budget plus reset
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

//--- common/core_pkg.sv
package core_pkg;

    // datapath width, fixed by rv32i
    localparam int XLEN = 32;

    // data or immediate word
    typedef logic [XLEN-1:0] xlen_t;
    // raw instruction word
    typedef logic [31:0] inst_t;
    // instruction address
    typedef logic [XLEN-1:0] pc_t;
    // supplier tag for one fetched instruction
    typedef logic [7:0] inst_id_t;
    // register index x0..x31
    typedef logic [4:0] reg_addr_t;

    // request address after reset
    localparam pc_t PC_RESET = '0;

    // decoded packet queue
    localparam int QUEUE_DEPTH = 2;
    localparam int QUEUE_PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // slot index into the queue
    typedef logic [QUEUE_PTR_W-1:0] qptr_t;
    // number of occupied slots, 0..QUEUE_DEPTH
    typedef logic [QUEUE_CNT_W-1:0] qcnt_t;

endpackage

//--- common/front_if.sv
`timescale 1ns/1ps

// decode register contents toward the decoder
interface fetch_if;
    logic                 id_valid;
    core_pkg::pc_t        id_pc;
    core_pkg::inst_t      id_inst;
    core_pkg::inst_id_t   id_inst_id;

    modport stage   (output id_valid, id_pc, id_inst, id_inst_id);
    modport decoder (input  id_valid, id_pc, id_inst, id_inst_id);
endinterface

// decoded packet push channel into the queue
interface dec_if;
    logic                   push_valid;
    logic                   push_ready;
    core_pkg::pc_t          pc;
    core_pkg::inst_id_t     inst_id;
    isa_pkg::inst_class_e   inst_class;
    core_pkg::reg_addr_t    rd;
    core_pkg::reg_addr_t    rs1;
    core_pkg::reg_addr_t    rs2;
    isa_pkg::funct3_t       funct3;
    core_pkg::xlen_t        imm;
    logic                   rf_wen;

    modport decoder (
        output push_valid, pc, inst_id, inst_class, rd, rs1, rs2, funct3, imm, rf_wen
    );
    modport queue (
        input  push_valid, pc, inst_id, inst_class, rd, rs1, rs2, funct3, imm, rf_wen,
        output push_ready
    );
    // decode stage only needs to know if the packet can leave
    modport front (input push_ready);
endinterface

//--- common/isa_pkg.sv
package isa_pkg;

    // major opcode, inst[6:0]
    typedef logic [6:0] opcode_t;
    // funct3 field, inst[14:12]
    typedef logic [2:0] funct3_t;

    // rv32i major opcodes
    localparam opcode_t OPC_LOAD   = 7'b000_0011;
    localparam opcode_t OPC_OP_IMM = 7'b001_0011;
    localparam opcode_t OPC_AUIPC  = 7'b001_0111;
    localparam opcode_t OPC_STORE  = 7'b010_0011;
    localparam opcode_t OPC_OP     = 7'b011_0011;
    localparam opcode_t OPC_LUI    = 7'b011_0111;
    localparam opcode_t OPC_BRANCH = 7'b110_0011;
    localparam opcode_t OPC_JALR   = 7'b110_0111;
    localparam opcode_t OPC_JAL    = 7'b110_1111;
    localparam opcode_t OPC_SYSTEM = 7'b111_0011;

    // instruction class seen by the downstream pipeline
    typedef enum logic [3:0] {
        CLASS_OP,
        CLASS_OP_IMM,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_BRANCH,
        CLASS_JAL,
        CLASS_JALR,
        CLASS_LUI,
        CLASS_AUIPC,
        CLASS_SYSTEM,
        CLASS_ILLEGAL
    } inst_class_e;

    // immediate layout, picked from the class
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_Z,
        IMM_NONE
    } imm_fmt_e;

endpackage

//--- logic/decode_front.sv
`timescale 1ns/1ps

module decode_front (
    input  logic                   clk,
    input  logic                   rst_i,

    // instruction responses from the supplier
    input  logic                   iresp_valid_i,
    output logic                   iresp_ready_o,
    input  core_pkg::pc_t          iresp_addr_i,
    input  core_pkg::inst_t        iresp_inst_i,
    input  core_pkg::inst_id_t     iresp_id_i,

    // refetch request, single-cycle pulse
    output logic                   ireq_valid_o,
    output core_pkg::pc_t          ireq_addr_o,

    // redirect from downstream
    input  logic                   redirect_i,
    input  core_pkg::pc_t          redirect_addr_i,

    // decoded packets toward the pipeline
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output core_pkg::pc_t          out_pc_o,
    output core_pkg::inst_id_t     out_inst_id_o,
    output isa_pkg::inst_class_e   out_class_o,
    output core_pkg::reg_addr_t    out_rd_o,
    output core_pkg::reg_addr_t    out_rs1_o,
    output core_pkg::reg_addr_t    out_rs2_o,
    output isa_pkg::funct3_t       out_funct3_o,
    output core_pkg::xlen_t        out_imm_o,
    output logic                   out_rf_wen_o
);

    fetch_if fetch_bus ();
    dec_if   dec_bus ();

    // decode register and redirect handling
    fetch_stage u_fetch_stage (
        .clk             (clk),
        .rst_i           (rst_i),
        .iresp_valid_i   (iresp_valid_i),
        .iresp_addr_i    (iresp_addr_i),
        .iresp_inst_i    (iresp_inst_i),
        .iresp_id_i      (iresp_id_i),
        .redirect_i      (redirect_i),
        .redirect_addr_i (redirect_addr_i),
        .iresp_ready_o   (iresp_ready_o),
        .ireq_valid_o    (ireq_valid_o),
        .ireq_addr_o     (ireq_addr_o),
        .fetch           (fetch_bus.stage),
        .dec             (dec_bus.front)
    );

    inst_decoder u_inst_decoder (
        .fetch (fetch_bus.decoder),
        .dec   (dec_bus.decoder)
    );

    // redirect empties the queue on the same edge
    ds_queue u_ds_queue (
        .clk           (clk),
        .rst_i         (rst_i),
        .flush_i       (redirect_i),
        .dec           (dec_bus.queue),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .out_pc_o      (out_pc_o),
        .out_inst_id_o (out_inst_id_o),
        .out_class_o   (out_class_o),
        .out_rd_o      (out_rd_o),
        .out_rs1_o     (out_rs1_o),
        .out_rs2_o     (out_rs2_o),
        .out_funct3_o  (out_funct3_o),
        .out_imm_o     (out_imm_o),
        .out_rf_wen_o  (out_rf_wen_o)
    );

endmodule

//--- logic/ds_queue.sv
`timescale 1ns/1ps

module ds_queue (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   flush_i,
    dec_if.queue                   dec,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output core_pkg::pc_t          out_pc_o,
    output core_pkg::inst_id_t     out_inst_id_o,
    output isa_pkg::inst_class_e   out_class_o,
    output core_pkg::reg_addr_t    out_rd_o,
    output core_pkg::reg_addr_t    out_rs1_o,
    output core_pkg::reg_addr_t    out_rs2_o,
    output isa_pkg::funct3_t       out_funct3_o,
    output core_pkg::xlen_t        out_imm_o,
    output logic                   out_rf_wen_o
);

    localparam int DEPTH = core_pkg::QUEUE_DEPTH;

    // packet storage, one array per field
    core_pkg::pc_t          pc_mem     [DEPTH];
    core_pkg::inst_id_t     id_mem     [DEPTH];
    isa_pkg::inst_class_e   class_mem  [DEPTH];
    core_pkg::reg_addr_t    rd_mem     [DEPTH];
    core_pkg::reg_addr_t    rs1_mem    [DEPTH];
    core_pkg::reg_addr_t    rs2_mem    [DEPTH];
    isa_pkg::funct3_t       funct3_mem [DEPTH];
    core_pkg::xlen_t        imm_mem    [DEPTH];
    logic                   wen_mem    [DEPTH];

    core_pkg::qptr_t   wr_ptr;
    core_pkg::qptr_t   rd_ptr;
    core_pkg::qcnt_t   count;
    logic              full;
    logic              push;
    logic              pop;

    // wrap at the last slot, depth need not be a power of two
    function automatic core_pkg::qptr_t next_ptr(input core_pkg::qptr_t ptr);
        core_pkg::qptr_t nxt;
        if (ptr == core_pkg::qptr_t'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign full        = (count == core_pkg::qcnt_t'(DEPTH));
    assign out_valid_o = (count != '0);
    // a full queue still takes a push when the head leaves
    assign dec.push_ready = !full || out_ready_i;

    assign push = dec.push_valid && dec.push_ready;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // count moves only when exactly one side fires
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]     <= dec.pc;
            id_mem[wr_ptr]     <= dec.inst_id;
            class_mem[wr_ptr]  <= dec.inst_class;
            rd_mem[wr_ptr]     <= dec.rd;
            rs1_mem[wr_ptr]    <= dec.rs1;
            rs2_mem[wr_ptr]    <= dec.rs2;
            funct3_mem[wr_ptr] <= dec.funct3;
            imm_mem[wr_ptr]    <= dec.imm;
            wen_mem[wr_ptr]    <= dec.rf_wen;
        end
    end

    // head packet, valid whenever count is nonzero
    assign out_pc_o      = pc_mem[rd_ptr];
    assign out_inst_id_o = id_mem[rd_ptr];
    assign out_class_o   = class_mem[rd_ptr];
    assign out_rd_o      = rd_mem[rd_ptr];
    assign out_rs1_o     = rs1_mem[rd_ptr];
    assign out_rs2_o     = rs2_mem[rd_ptr];
    assign out_funct3_o  = funct3_mem[rd_ptr];
    assign out_imm_o     = imm_mem[rd_ptr];
    assign out_rf_wen_o  = wen_mem[rd_ptr];

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 iresp_valid_i,
    input  core_pkg::pc_t        iresp_addr_i,
    input  core_pkg::inst_t      iresp_inst_i,
    input  core_pkg::inst_id_t   iresp_id_i,
    input  logic                 redirect_i,
    input  core_pkg::pc_t        redirect_addr_i,
    output logic                 iresp_ready_o,
    output logic                 ireq_valid_o,
    output core_pkg::pc_t        ireq_addr_o,
    fetch_if.stage               fetch,
    dec_if.front                 dec
);

    // decode stage register
    logic                 id_valid;
    core_pkg::pc_t        id_pc;
    core_pkg::inst_t      id_inst;
    core_pkg::inst_id_t   id_inst_id;

    // redirect seen on the previous edge
    logic                 redirect_q;
    core_pkg::pc_t        redirect_addr_q;

    logic                 id_stall;
    logic                 flush;
    logic                 accept;

    // held instruction that the queue cannot take
    assign id_stall = id_valid && !dec.push_ready;
    // drop everything on the redirect edge and the one after
    assign flush    = redirect_i || redirect_q;

    assign iresp_ready_o = !id_stall && !flush;
    assign accept        = iresp_valid_i && iresp_ready_o;

    // new fetch address goes out one cycle after the redirect
    assign ireq_valid_o = redirect_q;
    assign ireq_addr_o  = redirect_addr_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            redirect_q      <= 1'b0;
            redirect_addr_q <= core_pkg::PC_RESET;
            id_valid        <= 1'b0;
        end else begin
            redirect_q      <= redirect_i;
            redirect_addr_q <= redirect_addr_i;
            if (flush) begin
                id_valid <= 1'b0;
            end else if (!id_stall) begin
                // load on a response, otherwise go empty
                id_valid <= iresp_valid_i;
            end
        end
    end

    // payload only moves with an accepted response
    always_ff @(posedge clk) begin
        if (accept) begin
            id_pc      <= iresp_addr_i;
            id_inst    <= iresp_inst_i;
            id_inst_id <= iresp_id_i;
        end
    end

    assign fetch.id_valid   = id_valid;
    assign fetch.id_pc      = id_pc;
    assign fetch.id_inst    = id_inst;
    assign fetch.id_inst_id = id_inst_id;

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    fetch_if.decoder   fetch,
    dec_if.decoder     dec
);

    core_pkg::inst_t        inst;
    isa_pkg::opcode_t       opcode;
    isa_pkg::inst_class_e   inst_class;
    isa_pkg::imm_fmt_e      imm_fmt;
    core_pkg::xlen_t        imm;
    core_pkg::reg_addr_t    rd;
    logic                   writes_rd;

    assign inst   = fetch.id_inst;
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];

    // class straight from the major opcode
    always_comb begin
        case (opcode)
            isa_pkg::OPC_OP:     inst_class = isa_pkg::CLASS_OP;
            isa_pkg::OPC_OP_IMM: inst_class = isa_pkg::CLASS_OP_IMM;
            isa_pkg::OPC_LOAD:   inst_class = isa_pkg::CLASS_LOAD;
            isa_pkg::OPC_STORE:  inst_class = isa_pkg::CLASS_STORE;
            isa_pkg::OPC_BRANCH: inst_class = isa_pkg::CLASS_BRANCH;
            isa_pkg::OPC_JAL:    inst_class = isa_pkg::CLASS_JAL;
            isa_pkg::OPC_JALR:   inst_class = isa_pkg::CLASS_JALR;
            isa_pkg::OPC_LUI:    inst_class = isa_pkg::CLASS_LUI;
            isa_pkg::OPC_AUIPC:  inst_class = isa_pkg::CLASS_AUIPC;
            isa_pkg::OPC_SYSTEM: inst_class = isa_pkg::CLASS_SYSTEM;
            default:             inst_class = isa_pkg::CLASS_ILLEGAL;
        endcase
    end

    // format per class, csr immediate forms have funct3[2] set
    always_comb begin
        case (inst_class)
            isa_pkg::CLASS_OP_IMM,
            isa_pkg::CLASS_LOAD,
            isa_pkg::CLASS_JALR:   imm_fmt = isa_pkg::IMM_I;
            isa_pkg::CLASS_STORE:  imm_fmt = isa_pkg::IMM_S;
            isa_pkg::CLASS_BRANCH: imm_fmt = isa_pkg::IMM_B;
            isa_pkg::CLASS_JAL:    imm_fmt = isa_pkg::IMM_J;
            isa_pkg::CLASS_LUI,
            isa_pkg::CLASS_AUIPC:  imm_fmt = isa_pkg::IMM_U;
            isa_pkg::CLASS_SYSTEM: imm_fmt = inst[14] ? isa_pkg::IMM_Z : isa_pkg::IMM_I;
            default:               imm_fmt = isa_pkg::IMM_NONE;
        endcase
    end

    // immediate assembly, sign bit is always inst[31]
    always_comb begin
        case (imm_fmt)
            isa_pkg::IMM_I: imm = {{20{inst[31]}}, inst[31:20]};
            isa_pkg::IMM_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            isa_pkg::IMM_B: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                   inst[11:8], 1'b0};
            isa_pkg::IMM_U: imm = {inst[31:12], 12'b0};
            isa_pkg::IMM_J: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                   inst[30:21], 1'b0};
            // zero-extended rs1 field
            isa_pkg::IMM_Z: imm = core_pkg::xlen_t'(inst[19:15]);
            default:        imm = '0;
        endcase
    end

    // no write for store, branch or illegal
    assign writes_rd = (inst_class != isa_pkg::CLASS_STORE) &&
                       (inst_class != isa_pkg::CLASS_BRANCH) &&
                       (inst_class != isa_pkg::CLASS_ILLEGAL);

    assign dec.push_valid = fetch.id_valid;
    assign dec.pc         = fetch.id_pc;
    assign dec.inst_id    = fetch.id_inst_id;
    assign dec.inst_class = inst_class;
    assign dec.rd         = rd;
    assign dec.rs1        = inst[19:15];
    assign dec.rs2        = inst[24:20];
    assign dec.funct3     = inst[14:12];
    assign dec.imm        = imm;
    // x0 writes are dropped here
    assign dec.rf_wen     = writes_rd && (rd != '0);

endmodule
